//--- src/mastermind_defines.svh
`ifndef MASTERMIND_DEFINES_SVH
`define MASTERMIND_DEFINES_SVH

// game size
`define MM_PEGS             4
`define MM_TURNS            8

// divisors in clk cycles
`define MM_DEBOUNCE_DIV     4       // kept short for simulation
`define MM_BLINK_DIV        64      // half period of the cursor blink
`define MM_SCAN_DIV         8       // time each digit stays lit

// equal samples before a debounced level flips
`define MM_DEBOUNCE_DEPTH   3

`define MM_CODE_SEED        16'hb5a3

`endif

//--- src/mastermind_pkg.sv
package mastermind_pkg;

    localparam int PEG_W   = 3;     // eight colors
    localparam int SCORE_W = 3;     // counts 0 to 4

    typedef logic [PEG_W-1:0] peg_t;

    // p0 sits in the low bits
    typedef struct packed {
        peg_t p3;
        peg_t p2;
        peg_t p1;
        peg_t p0;
    } code_t;

    typedef struct packed {
        logic [SCORE_W-1:0] exact;
        logic [SCORE_W-1:0] near;
    } score_t;

    typedef struct packed {
        code_t  guess;
        score_t score;
    } turn_rec_t;

    // debounced levels or press pulses, one bit per input
    typedef struct packed {
        logic mode;
        logic sel;
        logic right;
        logic left;
        logic up;
        logic down;
    } buttons_t;

endpackage

//--- src/tick_gen.sv
`timescale 1ns/1ps
`include "mastermind_defines.svh"

module tick_gen (
    input  logic clk,
    input  logic reset,
    output logic debounce_tick,     // one cycle per debounce sample
    output logic blink_phase,       // cursor blink level
    output logic scan_tick          // one cycle per digit step
);

    localparam int DB_W    = $clog2(`MM_DEBOUNCE_DIV);
    localparam int BLINK_W = $clog2(`MM_BLINK_DIV);
    localparam int SCAN_W  = $clog2(`MM_SCAN_DIV);

    logic [DB_W-1:0]    db_cnt;
    logic [BLINK_W-1:0] blink_cnt;
    logic [SCAN_W-1:0]  scan_cnt;
    logic               blink_wrap;

    assign debounce_tick = (db_cnt == DB_W'(`MM_DEBOUNCE_DIV - 1));
    assign scan_tick     = (scan_cnt == SCAN_W'(`MM_SCAN_DIV - 1));
    assign blink_wrap    = (blink_cnt == BLINK_W'(`MM_BLINK_DIV - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            db_cnt      <= '0;
            blink_cnt   <= '0;
            scan_cnt    <= '0;
            blink_phase <= 1'b0;
        end else begin
            db_cnt    <= debounce_tick ? '0 : db_cnt + 1'b1;
            scan_cnt  <= scan_tick ? '0 : scan_cnt + 1'b1;
            blink_cnt <= blink_wrap ? '0 : blink_cnt + 1'b1;
            if (blink_wrap)
                blink_phase <= ~blink_phase;
        end
    end

    // enables must never stretch, or every consumer would double-step
    a_db_single: assert property (@(posedge clk) disable iff (reset)
        debounce_tick |=> !debounce_tick);
    a_scan_single: assert property (@(posedge clk) disable iff (reset)
        scan_tick |=> !scan_tick);

endmodule

//--- src/debouncer.sv
`timescale 1ns/1ps
`include "mastermind_defines.svh"

module debouncer (
    input  logic clk,
    input  logic reset,
    input  logic tick,      // sample enable
    input  logic raw,       // straight from the pin
    output logic level,     // stable state
    output logic press      // pulse as level rises
);

    localparam int CNT_W = $clog2(`MM_DEBOUNCE_DEPTH + 1);

    logic [1:0]       sync;     // two-flop synchronizer
    logic [CNT_W-1:0] cnt;      // differing samples seen so far
    logic             settle;

    // last differing sample needed before the level may flip
    assign settle = tick && (sync[1] != level) &&
                    (cnt == CNT_W'(`MM_DEBOUNCE_DEPTH - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            sync  <= '0;
            cnt   <= '0;
            level <= 1'b0;
            press <= 1'b0;
        end else begin
            sync  <= {sync[0], raw};
            press <= settle && sync[1];
            if (tick) begin
                if (sync[1] == level)
                    cnt <= '0;      // bounce, start over
                else if (settle) begin
                    cnt   <= '0;
                    level <= sync[1];
                end else
                    cnt <= cnt + 1'b1;
            end
        end
    end

    a_press_pulse: assert property (@(posedge clk) disable iff (reset)
        press |=> !press);

endmodule

//--- src/guess_editor.sv
`timescale 1ns/1ps

module guess_editor (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     mode,      // high in review
    input  mastermind_pkg::buttons_t presses,
    output mastermind_pkg::code_t    guess,
    output logic [1:0]               cursor     // 0 selects p0
);

    // pegs[0] is p0, same layout as code_t
    mastermind_pkg::peg_t [3:0] pegs;

    always_ff @(posedge clk) begin
        if (reset) begin
            pegs   <= '0;
            cursor <= '0;
        end else if (!mode) begin
            // two bit cursor wraps by itself
            if (presses.right)
                cursor <= cursor + 2'd1;
            else if (presses.left)
                cursor <= cursor - 2'd1;

            // colors step modulo 8
            if (presses.up)
                pegs[cursor] <= pegs[cursor] + 1'b1;
            else if (presses.down)
                pegs[cursor] <= pegs[cursor] - 1'b1;
        end
    end

    assign guess = mastermind_pkg::code_t'(pegs);

endmodule

//--- src/history.sv
`timescale 1ns/1ps
`include "mastermind_defines.svh"

module history (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      mode,
    input  mastermind_pkg::buttons_t  presses,
    input  logic                      commit,
    input  logic                      new_game,
    input  mastermind_pkg::turn_rec_t record_in,
    output mastermind_pkg::turn_rec_t shown,
    output logic [2:0]                shown_turn,
    output logic                      full
);

    localparam int CNT_W = $clog2(`MM_TURNS + 1);

    mastermind_pkg::turn_rec_t mem [`MM_TURNS];
    logic [CNT_W-1:0]          count;   // committed turns
    logic [2:0]                last;    // newest committed turn
    logic [2:0]                view;    // browsed turn in review
    logic [2:0]                idx;

    assign full = (count == CNT_W'(`MM_TURNS));
    assign last = (count == '0) ? 3'd0 : 3'(count - 1'b1);
    assign idx  = mode ? view : last;

    // play shows the turn in progress but the score of the latest one
    assign shown      = (count == '0) ? '0 : mem[idx];
    assign shown_turn = mode ? view :
                        full ? 3'(`MM_TURNS - 1) : count[2:0];

    always_ff @(posedge clk) begin
        if (commit)
            mem[count[2:0]] <= record_in;
    end

    always_ff @(posedge clk) begin
        if (reset || new_game) begin
            count <= '0;
            view  <= '0;
        end else begin
            if (commit)
                count <= count + 1'b1;
            if (!mode)
                view <= last;       // review opens on the newest turn
            else if (presses.up && view != last)
                view <= view + 3'd1;
            else if (presses.down && view != 3'd0)
                view <= view - 3'd1;
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        commit |-> !full);

endmodule

//--- src/referee.sv
`timescale 1ns/1ps
`include "mastermind_defines.svh"

module referee (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     mode,
    input  mastermind_pkg::buttons_t presses,
    input  mastermind_pkg::code_t    guess,
    input  logic                     full,
    output mastermind_pkg::score_t   score,
    output logic                     commit,
    output logic                     new_game,
    output logic                     game_over,
    output logic                     won
);

    localparam logic [15:0] SEED = `MM_CODE_SEED;
    localparam int COLORS = 1 << mastermind_pkg::PEG_W;

    logic [15:0]                           lfsr;
    logic                                  lfsr_fb;
    mastermind_pkg::code_t                 secret;
    mastermind_pkg::peg_t [`MM_PEGS-1:0]   g_pegs;
    mastermind_pkg::peg_t [`MM_PEGS-1:0]   s_pegs;
    logic [mastermind_pkg::SCORE_W-1:0]    n_exact;
    logic [mastermind_pkg::SCORE_W-1:0]    n_common;    // color matches, any spot
    logic [mastermind_pkg::SCORE_W-1:0]    n_g;
    logic [mastermind_pkg::SCORE_W-1:0]    n_s;
    logic                                  solved;

    assign lfsr_fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];  // taps 16 14 13 11
    assign g_pegs  = guess;
    assign s_pegs  = secret;

    always_comb begin
        n_exact  = '0;
        n_common = '0;
        n_g      = '0;
        n_s      = '0;
        for (int i = 0; i < `MM_PEGS; i++) begin
            if (g_pegs[i] == s_pegs[i])
                n_exact = n_exact + 1'b1;
        end
        for (int k = 0; k < COLORS; k++) begin
            n_g = '0;
            n_s = '0;
            for (int i = 0; i < `MM_PEGS; i++) begin
                if (g_pegs[i] == mastermind_pkg::PEG_W'(k))
                    n_g = n_g + 1'b1;
                if (s_pegs[i] == mastermind_pkg::PEG_W'(k))
                    n_s = n_s + 1'b1;
            end
            n_common = n_common + ((n_g < n_s) ? n_g : n_s);
        end
    end

    assign score.exact = n_exact;
    assign score.near  = n_common - n_exact;

    assign commit    = presses.sel && !mode && !game_over && !full;
    assign new_game  = presses.sel && game_over;
    assign game_over = solved || full;  // eighth commit ends it via full

    always_ff @(posedge clk) begin
        if (reset) begin
            lfsr   <= SEED;
            secret <= SEED[11:0];   // first game is predictable
            solved <= 1'b0;
            won    <= 1'b0;
        end else begin
            lfsr <= {lfsr[14:0], lfsr_fb};
            if (new_game) begin
                secret <= lfsr[11:0];
                solved <= 1'b0;
                won    <= 1'b0;
            end else if (commit && n_exact == mastermind_pkg::SCORE_W'(`MM_PEGS)) begin
                solved <= 1'b1;
                won    <= 1'b1;
            end
        end
    end

    a_excl: assert property (@(posedge clk) disable iff (reset)
        !(commit && new_game));

endmodule

//--- src/ssd_driver.sv
`timescale 1ns/1ps

module ssd_driver (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   scan_tick,
    input  mastermind_pkg::score_t score,
    input  logic [2:0]             turn,
    input  logic                   game_over,
    input  logic                   won,
    output logic [7:0]             seg,     // {dp, g..a}, active low
    output logic [3:0]             an       // active low
);

    localparam logic [3:0] SYM_P     = 4'hd;
    localparam logic [3:0] SYM_BLANK = 4'he;
    localparam logic [3:0] SYM_F     = 4'hf;

    logic [1:0] digit;
    logic       active;     // stays low until the first scan tick
    logic [3:0] value;
    logic [6:0] pattern;

    always_ff @(posedge clk) begin
        if (reset) begin
            digit  <= '0;
            active <= 1'b0;
        end else if (scan_tick) begin
            active <= 1'b1;
            if (active)
                digit <= digit + 2'd1;
        end
    end

    always_comb begin
        case (digit)
            2'd0:    value = {1'b0, score.exact};
            2'd1:    value = {1'b0, score.near};
            2'd2:    value = {1'b0, turn} + 4'd1;   // turns count from 1
            default: value = !game_over ? SYM_BLANK : won ? SYM_P : SYM_F;
        endcase
        case (value)
            4'h0:    pattern = 7'b1000000;
            4'h1:    pattern = 7'b1111001;
            4'h2:    pattern = 7'b0100100;
            4'h3:    pattern = 7'b0110000;
            4'h4:    pattern = 7'b0011001;
            4'h5:    pattern = 7'b0010010;
            4'h6:    pattern = 7'b0000010;
            4'h7:    pattern = 7'b1111000;
            4'h8:    pattern = 7'b0000000;
            4'h9:    pattern = 7'b0010000;
            SYM_P:   pattern = 7'b0001100;
            SYM_F:   pattern = 7'b0001110;
            default: pattern = 7'b1111111;
        endcase
    end

    assign seg = {1'b1, pattern};   // dp never lit
    assign an  = active ? ~(4'b0001 << digit) : 4'b1111;

    a_one_cold: assert property (@(posedge clk) disable iff (reset)
        active |-> $onehot(~an));

endmodule

//--- src/mastermind.sv
`timescale 1ns/1ps
`include "mastermind_defines.svh"

module mastermind (
    input  logic       clk,
    input  logic       reset,
    input  logic       sw,          // high for review
    input  logic       btn_s,       // select
    input  logic       btn_r,
    input  logic       btn_l,
    input  logic       btn_u,
    input  logic       btn_d,
    output logic [7:0] seg,
    output logic [3:0] an,
    output logic [2:0] rgb0_out,
    output logic [2:0] rgb1_out,
    output logic [2:0] rgb2_out,
    output logic [2:0] rgb3_out,
    output logic [7:0] sw_led       // leds above the switches
);

    logic                      debounce_tick;
    logic                      blink_phase;
    logic                      scan_tick;
    logic [5:0]                raw;
    logic [5:0]                level_bits;
    logic [5:0]                press_bits;
    mastermind_pkg::buttons_t  levels;
    mastermind_pkg::buttons_t  presses;
    mastermind_pkg::code_t     guess;
    logic [1:0]                cursor;
    mastermind_pkg::score_t    score;
    mastermind_pkg::turn_rec_t record_in;
    mastermind_pkg::turn_rec_t shown;
    logic [2:0]                shown_turn;
    logic                      full;
    logic                      commit;
    logic                      new_game;
    logic                      game_over;
    logic                      won;
    mastermind_pkg::peg_t [`MM_PEGS-1:0] guess_pegs;
    mastermind_pkg::peg_t [`MM_PEGS-1:0] shown_pegs;
    mastermind_pkg::peg_t [`MM_PEGS-1:0] rgb;

    tick_gen tick_gen0 (
        .clk(clk),
        .reset(reset),
        .debounce_tick(debounce_tick),
        .blink_phase(blink_phase),
        .scan_tick(scan_tick)
    );

    // bit order follows buttons_t, mode on top
    assign raw = {sw, btn_s, btn_r, btn_l, btn_u, btn_d};

    for (genvar i = 0; i < 6; i++) begin : g_db
        debouncer db (
            .clk(clk),
            .reset(reset),
            .tick(debounce_tick),
            .raw(raw[i]),
            .level(level_bits[i]),
            .press(press_bits[i])
        );
    end

    assign levels  = level_bits;
    assign presses = press_bits;

    guess_editor guess0 (
        .clk(clk),
        .reset(reset),
        .mode(levels.mode),
        .presses(presses),
        .guess(guess),
        .cursor(cursor)
    );

    assign record_in.guess = guess;
    assign record_in.score = score;

    history hist0 (
        .clk(clk),
        .reset(reset),
        .mode(levels.mode),
        .presses(presses),
        .commit(commit),
        .new_game(new_game),
        .record_in(record_in),
        .shown(shown),
        .shown_turn(shown_turn),
        .full(full)
    );

    referee ref0 (
        .clk(clk),
        .reset(reset),
        .mode(levels.mode),
        .presses(presses),
        .guess(guess),
        .full(full),
        .score(score),
        .commit(commit),
        .new_game(new_game),
        .game_over(game_over),
        .won(won)
    );

    ssd_driver ssd0 (
        .clk(clk),
        .reset(reset),
        .scan_tick(scan_tick),
        .score(shown.score),
        .turn(shown_turn),
        .game_over(game_over),
        .won(won),
        .seg(seg),
        .an(an)
    );

    assign guess_pegs = guess;
    assign shown_pegs = shown.guess;

    // review shows history, play shows the guess with a blinking cursor peg
    always_comb begin
        for (int p = 0; p < `MM_PEGS; p++) begin
            if (levels.mode)
                rgb[p] = shown_pegs[p];
            else if (blink_phase && cursor == 2'(p))
                rgb[p] = '0;
            else
                rgb[p] = guess_pegs[p];
        end
    end

    assign rgb0_out = rgb[0];
    assign rgb1_out = rgb[1];
    assign rgb2_out = rgb[2];
    assign rgb3_out = rgb[3];

    assign sw_led = game_over ? 8'hff : 8'b1 << shown_turn;    // all lit once over

endmodule

//--- tb/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    input  logic restart,   // asks for another reset
    output logic clk,
    output logic reset
);

    int hold_cycles;        // edges left with reset high

    initial clk = 1'b0;
    always #50 clk = ~clk;  // 100 ns period

    initial begin
        reset       = 1'b1;
        hold_cycles = 2;
        forever begin
            @(posedge clk);
            if (restart)
                hold_cycles = 2;
            else if (hold_cycles > 0)
                hold_cycles = hold_cycles - 1;
            #10 reset = (hold_cycles > 0);
        end
    end

endmodule

//--- tb/tb_mastermind.sv
`timescale 1ns/1ps
`include "mastermind_defines.svh"

module tb_mastermind;

    localparam int B_SEL      = 0;
    localparam int B_RIGHT    = 1;
    localparam int B_LEFT     = 2;
    localparam int B_UP       = 3;
    localparam int B_DOWN     = 4;
    localparam int SYM_P      = 10;
    localparam int SYM_F      = 11;
    localparam int SYM_BLANK  = 12;
    localparam int WAIT_LIMIT = 200;    // cycles
    localparam int HOLD       = 30;     // cycles per press phase

    logic       clk;
    logic       reset;
    logic       restart;
    logic       sw;
    logic       btn_s;
    logic       btn_r;
    logic       btn_l;
    logic       btn_u;
    logic       btn_d;
    logic [7:0] seg;
    logic [3:0] an;
    logic [2:0] rgb0_out;
    logic [2:0] rgb1_out;
    logic [2:0] rgb2_out;
    logic [2:0] rgb3_out;
    logic [7:0] sw_led;

    // model of the game, p0 in the low bits
    logic [11:0] secret;
    logic [11:0] model_guess;
    int          model_cursor;
    int          model_count;
    logic        model_over;
    logic        model_won;
    logic [11:0] hist_guess [`MM_TURNS];
    logic [5:0]  hist_score [`MM_TURNS];   // {exact, near}
    logic [31:0] rng_state;
    logic [11:0] code;

    tb_clock clock0 (
        .restart(restart),
        .clk(clk),
        .reset(reset)
    );

    mastermind dut0 (
        .clk(clk),
        .reset(reset),
        .sw(sw),
        .btn_s(btn_s),
        .btn_r(btn_r),
        .btn_l(btn_l),
        .btn_u(btn_u),
        .btn_d(btn_d),
        .seg(seg),
        .an(an),
        .rgb0_out(rgb0_out),
        .rgb1_out(rgb1_out),
        .rgb2_out(rgb2_out),
        .rgb3_out(rgb3_out),
        .sw_led(sw_led)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // exact hits, then per color overlap minus exact
    function automatic logic [5:0] score_of(input logic [11:0] g, input logic [11:0] s);
        int exact;
        int common;
        int n_g;
        int n_s;
        exact  = 0;
        common = 0;
        for (int p = 0; p < `MM_PEGS; p++) begin
            if (g[3*p +: 3] == s[3*p +: 3])
                exact++;
        end
        for (int c = 0; c < 8; c++) begin
            n_g = 0;
            n_s = 0;
            for (int p = 0; p < `MM_PEGS; p++) begin
                if (int'(g[3*p +: 3]) == c)
                    n_g++;
                if (int'(s[3*p +: 3]) == c)
                    n_s++;
            end
            common += (n_g < n_s) ? n_g : n_s;
        end
        return {3'(exact), 3'(common - exact)};
    endfunction

    // {dp, g..a}, active low
    function automatic logic [7:0] seg_code(input int sym);
        case (sym)
            0:       return 8'hc0;
            1:       return 8'hf9;
            2:       return 8'ha4;
            3:       return 8'hb0;
            4:       return 8'h99;
            5:       return 8'h92;
            6:       return 8'h82;
            7:       return 8'hf8;
            8:       return 8'h80;
            9:       return 8'h90;
            SYM_P:   return 8'h8c;
            SYM_F:   return 8'h8e;
            default: return 8'hff;
        endcase
    endfunction

    function automatic logic [2:0] rgb_of(input int p);
        case (p)
            0:       return rgb0_out;
            1:       return rgb1_out;
            2:       return rgb2_out;
            default: return rgb3_out;
        endcase
    endfunction

    task automatic fail_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("SOME TESTS FAILED");
        $fatal(1, "timeout");
    endtask

    task automatic check(input string name, input int expected, input int actual);
        assert (expected == actual) else begin
            $display("ERROR at %0t: %s expected %0h actual %0h", $time, name, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic set_button(input int which, input logic value);
        case (which)
            B_SEL:   btn_s = value;
            B_RIGHT: btn_r = value;
            B_LEFT:  btn_l = value;
            B_UP:    btn_u = value;
            default: btn_d = value;
        endcase
    endtask

    task automatic press(input int which);
        @(posedge clk);
        #10 set_button(which, 1'b1);
        repeat (HOLD) @(posedge clk);
        #10 set_button(which, 1'b0);
        repeat (HOLD) @(posedge clk);
    endtask

    // press in play mode and follow it in the model
    task automatic edit(input int which);
        int cp;
        press(which);
        cp = 3 * model_cursor;
        case (which)
            B_RIGHT: model_cursor = (model_cursor + 1) % 4;
            B_LEFT:  model_cursor = (model_cursor + 3) % 4;
            B_UP:    model_guess[cp +: 3] = model_guess[cp +: 3] + 3'd1;
            B_DOWN:  model_guess[cp +: 3] = model_guess[cp +: 3] - 3'd1;
            default: ;
        endcase
    endtask

    task automatic set_mode(input logic value);
        @(posedge clk);
        #10 sw = value;
        repeat (HOLD) @(posedge clk);
    endtask

    task automatic wait_reset_release();
        int n;
        @(negedge clk);
        for (n = 0; n < WAIT_LIMIT && reset; n++)
            @(negedge clk);
        if (reset)
            fail_timeout("reset to be released");
    endtask

    task automatic wait_blink(input logic phase);
        int n;
        for (n = 0; n < WAIT_LIMIT && dut0.blink_phase != phase; n++)
            @(negedge clk);
        if (dut0.blink_phase != phase)
            fail_timeout(phase ? "blink phase to go high" : "blink phase to go low");
    endtask

    task automatic check_digit(input int d, input int sym);
        logic [3:0] want_an;
        int         n;
        want_an = ~(4'b0001 << d);
        @(negedge clk);
        for (n = 0; n < WAIT_LIMIT && an != want_an; n++)
            @(negedge clk);
        if (an != want_an)
            fail_timeout($sformatf("digit %0d to be scanned", d));
        check($sformatf("seg digit %0d", d), seg_code(sym), seg);
    endtask

    task automatic check_pegs();
        @(negedge clk);
        for (int p = 0; p < `MM_PEGS; p++) begin
            if (p != model_cursor)
                check($sformatf("rgb%0d_out", p), model_guess[3*p +: 3], rgb_of(p));
        end
        wait_blink(1'b1);
        check($sformatf("rgb%0d_out", model_cursor), 0, rgb_of(model_cursor)); // blanked
        wait_blink(1'b0);
        check($sformatf("rgb%0d_out", model_cursor), model_guess[3*model_cursor +: 3],
              rgb_of(model_cursor));
    endtask

    task automatic check_play_display();
        logic [5:0] sc;
        sc = (model_count == 0) ? 6'd0 : hist_score[model_count-1];
        @(negedge clk);
        check("sw_led", model_over ? 8'hff : 8'h01 << model_count, sw_led);
        check_digit(0, sc[5:3]);
        check_digit(1, sc[2:0]);
        check_digit(2, (model_count == `MM_TURNS) ? `MM_TURNS : model_count + 1);
        check_digit(3, !model_over ? SYM_BLANK : model_won ? SYM_P : SYM_F);
    endtask

    task automatic check_review(input int v);
        @(negedge clk);
        for (int p = 0; p < `MM_PEGS; p++)
            check($sformatf("rgb%0d_out", p), hist_guess[v][3*p +: 3], rgb_of(p));
        check("sw_led", 8'h01 << v, sw_led);
        check_digit(0, hist_score[v][5:3]);
        check_digit(1, hist_score[v][2:0]);
        check_digit(2, v + 1);
    endtask

    task automatic enter_guess(input logic [11:0] target);
        int diff;
        for (int p = 0; p < `MM_PEGS; p++) begin
            while (model_cursor != p)
                edit(B_RIGHT);
            diff = (int'(target[3*p +: 3]) - int'(model_guess[3*p +: 3]) + 8) % 8;
            if (diff <= 4)
                repeat (diff) edit(B_UP);
            else
                repeat (8 - diff) edit(B_DOWN);
        end
    endtask

    task automatic commit_guess(input logic [11:0] g);
        int idx;
        idx = model_count;
        enter_guess(g);
        press(B_SEL);
        hist_guess[idx] = g;
        hist_score[idx] = score_of(g, secret);
        model_count     = idx + 1;
        model_won       = (hist_score[idx][5:3] == 3'd4);
        model_over      = model_won || model_count == `MM_TURNS;
        check_play_display();
    endtask

    task automatic random_code(output logic [11:0] c);
        rng_state = xorshift(rng_state);
        c = rng_state[11:0];
        if (c == secret)
            c[2:0] = c[2:0] + 3'd1;     // keep it a wrong guess
    endtask

    task automatic start_game();
        logic [15:0] seed;
        seed         = `MM_CODE_SEED;
        model_guess  = '0;
        model_cursor = 0;
        model_count  = 0;
        model_over   = 1'b0;
        model_won    = 1'b0;
        for (int p = 0; p < `MM_PEGS; p++)
            secret[3*p +: 3] = seed[3*p +: 3];
    endtask

    task automatic restart_game();
        @(posedge clk);
        #10 restart = 1'b1;
        @(posedge clk);
        #10 restart = 1'b0;
        wait_reset_release();
        start_game();
    endtask

    initial begin
        sw        = 1'b0;
        btn_s     = 1'b0;
        btn_r     = 1'b0;
        btn_l     = 1'b0;
        btn_u     = 1'b0;
        btn_d     = 1'b0;
        restart   = 1'b0;
        rng_state = 32'hf1a0;

        wait_reset_release();
        start_game();
        check("an", 4'hf, an);          // no scan tick yet
        check("sw_led", 8'h01, sw_led);
        for (int p = 0; p < `MM_PEGS; p++)
            check($sformatf("rgb%0d_out", p), 0, rgb_of(p));

        edit(B_RIGHT);
        edit(B_RIGHT);
        repeat (3) edit(B_UP);
        edit(B_LEFT);
        edit(B_DOWN);                   // wraps 0 to 7
        check_pegs();

        repeat (3) begin
            random_code(code);
            commit_guess(code);
        end

        // browse the three stored turns, clamped at both ends
        set_mode(1'b1);
        check_review(2);
        press(B_DOWN);
        check_review(1);
        press(B_DOWN);
        check_review(0);
        press(B_DOWN);
        check_review(0);
        repeat (3) press(B_UP);
        check_review(2);
        set_mode(1'b0);
        check_pegs();
        check_play_display();

        commit_guess(secret);
        press(B_SEL);                   // starts a new game, no turn added
        model_count = 0;
        model_over  = 1'b0;
        model_won   = 1'b0;
        check_play_display();

        restart_game();
        repeat (`MM_TURNS) begin
            random_code(code);
            commit_guess(code);
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+src
src/mastermind_pkg.sv
src/tick_gen.sv
src/debouncer.sv
src/guess_editor.sv
src/history.sv
src/referee.sv
src/ssd_driver.sv
src/mastermind.sv
tb/tb_clock.sv
tb/tb_mastermind.sv

//--- Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS := --lint-only --timing -Wall
TOP       := tb_mastermind
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
